// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int tag_width    = 32 - index_width - offset_width;  // 26
    localparam int num_sets     = 16;
    localparam int num_ways     = 2;  // way logic in the fsm assumes two

    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            word_t;
    typedef logic [3:0]             strb_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [num_ways-1:0]    way_vec_t;

    // maintenance ops, 2'd3 unused
    typedef enum logic [1:0] {
        op_index_init  = 2'd0,
        op_index_inval = 2'd1,
        op_hit_inval   = 2'd2
    } cache_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_operation,
        st_flush,
        st_hit_w,
        st_miss_w,
        st_miss_rd,
        st_miss_rd_fill
    } fsm_state_t;

endpackage

`default_nettype wire

// File: src/dcache_req_buf.sv
`default_nettype none

module dcache_req_buf (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  rbuf_we,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::strb_t     wstrb,
    input  logic                  is_write,
    input  logic                  uncached,
    input  dcache_pkg::cache_op_t op,
    output dcache_pkg::addr_t     buf_addr,
    output dcache_pkg::tag_t      buf_tag,
    output dcache_pkg::index_t    buf_index,
    output dcache_pkg::word_t     buf_wdata,
    output dcache_pkg::strb_t     buf_wstrb,
    output logic                  buf_write,
    output logic                  buf_uncached,
    output dcache_pkg::cache_op_t buf_op
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_write    <= 1'b0;
            buf_uncached <= 1'b0;
        end else if (rbuf_we) begin
            buf_write    <= is_write;
            buf_uncached <= uncached;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            buf_addr  <= addr;
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
            buf_op    <= op;
        end
    end

    assign buf_index = buf_addr[dcache_pkg::offset_width +: dcache_pkg::index_width];
    assign buf_tag   = buf_addr[31 -: dcache_pkg::tag_width];

    // op field must hold a defined encoding once loaded
    a_op_legal: assert property (@(posedge clk) disable iff (!rstn)
        rbuf_we |=> buf_op inside {dcache_pkg::op_index_init, dcache_pkg::op_index_inval,
                                   dcache_pkg::op_hit_inval});

endmodule

`default_nettype wire

// File: src/dcache_store.sv
`default_nettype none

module dcache_store (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::tag_t     lookup_tag,
    input  dcache_pkg::index_t   lookup_index,
    input  dcache_pkg::word_t    wdata,
    input  dcache_pkg::strb_t    wstrb,
    input  dcache_pkg::word_t    refill_data,
    input  dcache_pkg::way_vec_t data_we,
    input  logic                 refill,
    input  dcache_pkg::way_vec_t tag_inval,
    input  logic                 tag_init,
    input  logic                 init_way,
    input  logic                 use0,
    input  logic                 use1,
    output dcache_pkg::way_vec_t hit,
    output dcache_pkg::word_t    way_data0,
    output dcache_pkg::word_t    way_data1,
    output logic                 victim_way
);

    dcache_pkg::tag_t                tag_arr  [dcache_pkg::num_ways][dcache_pkg::num_sets];
    dcache_pkg::word_t               data_arr [dcache_pkg::num_ways][dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid_arr [dcache_pkg::num_ways];
    logic [dcache_pkg::num_sets-1:0] lru;  // per set, the way to replace next

    // valid bits and lru
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                valid_arr[w] <= '0;
            end
            lru <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) begin
                if (tag_inval[w] || (tag_init && init_way == 1'(w))) begin
                    valid_arr[w][lookup_index] <= 1'b0;
                end else if (data_we[w] && refill) begin
                    valid_arr[w][lookup_index] <= 1'b1;
                end
            end
            if (use0)      lru[lookup_index] <= 1'b1;
            else if (use1) lru[lookup_index] <= 1'b0;
        end
    end

    // tags and data
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (data_we[w]) begin
                if (refill) begin
                    data_arr[w][lookup_index] <= refill_data;
                    tag_arr[w][lookup_index]  <= lookup_tag;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) data_arr[w][lookup_index][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else if (tag_init && init_way == 1'(w)) begin
                tag_arr[w][lookup_index] <= '0;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit[w] = valid_arr[w][lookup_index] && (tag_arr[w][lookup_index] == lookup_tag);
        end
    end

    assign way_data0  = data_arr[0][lookup_index];
    assign way_data1  = data_arr[1][lookup_index];
    assign victim_way = lru[lookup_index];

    a_we_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(data_we));
    // a line lives in one way only
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

`default_nettype wire

// File: src/dcache_read_mux.sv
`default_nettype none

module dcache_read_mux (
    input  logic              clk,
    input  logic              rstn,
    input  logic              mem_data_ok,
    input  dcache_pkg::word_t mem_rdata,
    input  logic              choose_return,
    input  logic              choose_way,
    input  dcache_pkg::word_t way_data0,
    input  dcache_pkg::word_t way_data1,
    output dcache_pkg::word_t rdata,
    output dcache_pkg::word_t refill_data
);

    logic ret_sel;  // high for the cycle after a capture

    always_ff @(posedge clk) begin
        if (choose_return && mem_data_ok) refill_data <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rstn) ret_sel <= 1'b0;
        else       ret_sel <= choose_return && mem_data_ok;
    end

    assign rdata = ret_sel    ? refill_data :
                   choose_way ? way_data1   : way_data0;

endmodule

`default_nettype wire

// File: src/dcache_main_fsm.sv
`default_nettype none

module dcache_main_fsm (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  valid,
    input  logic                  is_op,
    input  logic                  flush,
    input  logic                  buf_write,
    input  logic                  buf_uncached,
    input  dcache_pkg::cache_op_t buf_op,
    input  logic                  init_sel,
    input  dcache_pkg::way_vec_t  hit,
    input  logic                  victim_way,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    output logic                  ready,
    output logic                  rbuf_we,
    output logic                  op_done,
    output logic                  rdata_valid,
    output logic                  mem_req,
    output logic                  mem_wr,
    output dcache_pkg::way_vec_t  data_we,
    output logic                  refill,
    output dcache_pkg::way_vec_t  tag_inval,
    output logic                  tag_init,
    output logic                  init_way,
    output logic                  use0,
    output logic                  use1,
    output logic                  choose_way,
    output logic                  choose_return
);

    dcache_pkg::fsm_state_t state;
    dcache_pkg::fsm_state_t next_state;
    dcache_pkg::fsm_state_t next_req;  // where an accepted request goes
    logic                   miss;

    assign miss    = (hit == '0) || buf_uncached;
    assign op_done = (state == dcache_pkg::st_operation);

    always_ff @(posedge clk) begin
        if (!rstn) state <= dcache_pkg::st_idle;
        else       state <= next_state;
    end

    always_comb begin
        if (!valid)     next_req = dcache_pkg::st_idle;
        else if (is_op) next_req = dcache_pkg::st_operation;
        else            next_req = dcache_pkg::st_lookup;
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = dcache_pkg::st_idle;
        case (state)
            dcache_pkg::st_idle,
            dcache_pkg::st_operation: next_state = next_req;
            dcache_pkg::st_lookup: begin
                if (flush) begin
                    next_state = dcache_pkg::st_flush;
                end else if (buf_write) begin
                    if (mem_addr_ok) next_state = next_req;
                    else if (miss)   next_state = dcache_pkg::st_miss_w;
                    else             next_state = dcache_pkg::st_hit_w;
                end else if (miss) begin
                    next_state = dcache_pkg::st_miss_rd;
                end else begin
                    next_state = next_req;  // read hit, back to back
                end
            end
            dcache_pkg::st_flush:
                next_state = flush ? dcache_pkg::st_flush : next_req;
            dcache_pkg::st_hit_w,
            dcache_pkg::st_miss_w:
                next_state = mem_addr_ok ? next_req : state;
            dcache_pkg::st_miss_rd:
                next_state = mem_data_ok ? dcache_pkg::st_miss_rd_fill : dcache_pkg::st_miss_rd;
            dcache_pkg::st_miss_rd_fill: next_state = next_req;
            default: next_state = dcache_pkg::st_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ready         = 1'b0;
        rbuf_we       = 1'b0;
        rdata_valid   = 1'b0;
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        data_we       = '0;
        refill        = 1'b0;
        tag_inval     = '0;
        tag_init      = 1'b0;
        init_way      = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        choose_way    = 1'b0;
        choose_return = 1'b0;
        case (state)
            dcache_pkg::st_idle: begin
                ready   = 1'b1;
                rbuf_we = 1'b1;
            end
            dcache_pkg::st_lookup: begin
                if (!flush) begin
                    if (buf_uncached) tag_inval = hit;  // drop a stale copy
                    if (buf_write || miss) begin
                        mem_req = 1'b1;
                        mem_wr  = buf_write;
                    end
                    if (!miss) begin
                        if (buf_write) begin
                            data_we = hit;
                        end else begin
                            choose_way  = hit[1];
                            rdata_valid = 1'b1;
                        end
                        use0 = hit[0];
                        use1 = hit[1];
                    end
                    if ((buf_write && mem_addr_ok) || (!buf_write && !miss)) begin
                        ready   = 1'b1;
                        rbuf_we = 1'b1;
                    end
                end
            end
            dcache_pkg::st_operation: begin
                ready   = 1'b1;
                rbuf_we = 1'b1;
                case (buf_op)
                    dcache_pkg::op_index_init: begin
                        tag_init = 1'b1;
                        init_way = init_sel;
                    end
                    dcache_pkg::op_index_inval: tag_inval[init_sel] = 1'b1;
                    dcache_pkg::op_hit_inval:   tag_inval = hit;
                    default: ;
                endcase
            end
            dcache_pkg::st_flush: begin
                ready   = !flush;
                rbuf_we = !flush;
            end
            dcache_pkg::st_hit_w,
            dcache_pkg::st_miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                ready   = mem_addr_ok;
                rbuf_we = mem_addr_ok;
            end
            dcache_pkg::st_miss_rd: begin
                mem_req       = 1'b1;
                choose_return = mem_data_ok;
            end
            dcache_pkg::st_miss_rd_fill: begin
                ready       = 1'b1;
                rbuf_we     = 1'b1;
                rdata_valid = 1'b1;
                refill      = 1'b1;
                if (!buf_uncached) begin  // uncached data never enters the arrays
                    data_we[victim_way] = 1'b1;
                    use0 = !victim_way;
                    use1 = victim_way;
                end
            end
            default: ;
        endcase
    end

    // a memory request stays up until memory answers it
    a_wr_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && mem_wr && !mem_addr_ok |=> mem_req && mem_wr);
    a_rd_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_wr && !mem_data_ok |=> mem_req && !mem_wr);

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic                  clk,
    input  logic                  rstn,
    // pipeline side
    input  logic                  valid,
    input  dcache_pkg::addr_t     addr,
    input  dcache_pkg::word_t     wdata,
    input  dcache_pkg::strb_t     wstrb,
    input  logic                  is_write,
    input  logic                  uncached,
    input  logic                  is_op,
    input  dcache_pkg::cache_op_t op,
    input  logic                  flush,
    output logic                  ready,
    output dcache_pkg::word_t     rdata,
    output logic                  rdata_valid,
    output logic                  op_done,
    // memory side
    output logic                  mem_req,
    output logic                  mem_wr,
    output dcache_pkg::addr_t     mem_addr,
    output dcache_pkg::word_t     mem_wdata,
    output dcache_pkg::strb_t     mem_wstrb,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    input  dcache_pkg::word_t     mem_rdata
);

    logic                  rbuf_we;
    dcache_pkg::tag_t      buf_tag;
    dcache_pkg::index_t    buf_index;
    logic                  buf_write;
    logic                  buf_uncached;
    dcache_pkg::cache_op_t buf_op;
    dcache_pkg::way_vec_t  hit;
    dcache_pkg::way_vec_t  data_we;
    dcache_pkg::way_vec_t  tag_inval;
    logic                  victim_way;
    logic                  refill;
    logic                  tag_init;
    logic                  init_way;
    logic                  use0;
    logic                  use1;
    logic                  choose_way;
    logic                  choose_return;
    dcache_pkg::word_t     way_data0;
    dcache_pkg::word_t     way_data1;
    dcache_pkg::word_t     refill_data;

    dcache_req_buf u_req_buf (
        .clk          (clk),
        .rstn         (rstn),
        .rbuf_we      (rbuf_we),
        .addr         (addr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .is_write     (is_write),
        .uncached     (uncached),
        .op           (op),
        .buf_addr     (mem_addr),
        .buf_tag      (buf_tag),
        .buf_index    (buf_index),
        .buf_wdata    (mem_wdata),
        .buf_wstrb    (mem_wstrb),
        .buf_write    (buf_write),
        .buf_uncached (buf_uncached),
        .buf_op       (buf_op)
    );

    dcache_main_fsm u_main_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .valid         (valid),
        .is_op         (is_op),
        .flush         (flush),
        .buf_write     (buf_write),
        .buf_uncached  (buf_uncached),
        .buf_op        (buf_op),
        .init_sel      (buf_tag[0]),  // first address bit above the index
        .hit           (hit),
        .victim_way    (victim_way),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .ready         (ready),
        .rbuf_we       (rbuf_we),
        .op_done       (op_done),
        .rdata_valid   (rdata_valid),
        .mem_req       (mem_req),
        .mem_wr        (mem_wr),
        .data_we       (data_we),
        .refill        (refill),
        .tag_inval     (tag_inval),
        .tag_init      (tag_init),
        .init_way      (init_way),
        .use0          (use0),
        .use1          (use1),
        .choose_way    (choose_way),
        .choose_return (choose_return)
    );

    dcache_store u_store (
        .clk          (clk),
        .rstn         (rstn),
        .lookup_tag   (buf_tag),
        .lookup_index (buf_index),
        .wdata        (mem_wdata),
        .wstrb        (mem_wstrb),
        .refill_data  (refill_data),
        .data_we      (data_we),
        .refill       (refill),
        .tag_inval    (tag_inval),
        .tag_init     (tag_init),
        .init_way     (init_way),
        .use0         (use0),
        .use1         (use1),
        .hit          (hit),
        .way_data0    (way_data0),
        .way_data1    (way_data1),
        .victim_way   (victim_way)
    );

    dcache_read_mux u_read_mux (
        .clk           (clk),
        .rstn          (rstn),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata),
        .choose_return (choose_return),
        .choose_way    (choose_way),
        .way_data0     (way_data0),
        .way_data1     (way_data1),
        .rdata         (rdata),
        .refill_data   (refill_data)
    );

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`default_nettype none

module mem_model (
    input  logic              clk,
    input  logic              rstn,
    input  logic              mem_req,
    input  logic              mem_wr,
    input  dcache_pkg::addr_t mem_addr,
    input  dcache_pkg::word_t mem_wdata,
    input  dcache_pkg::strb_t mem_wstrb,
    output logic              mem_addr_ok,
    output logic              mem_data_ok,
    output dcache_pkg::word_t mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_delay = 5;

    dcache_pkg::word_t mem [1024];
    logic              busy;
    int unsigned       wait_cnt;
    logic [9:0]        widx;

    assign widx = mem_addr[11:2];

    task automatic set_word(input logic [9:0] idx, input dcache_pkg::word_t val);
        mem[idx] = val;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            busy        <= 1'b0;
            wait_cnt    <= 0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if (mem_addr_ok && mem_req && mem_wr) begin  // write completes here
                for (int b = 0; b < 4; b++) begin
                    if (mem_wstrb[b]) mem[widx][8*b +: 8] = mem_wdata[8*b +: 8];
                end
            end
            // a new request starts only after the previous one is acknowledged
            if (mem_req && !mem_addr_ok && !mem_data_ok) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= $urandom_range(max_delay, 0);
                end else if (wait_cnt == 0) begin
                    busy <= 1'b0;
                    if (mem_wr) begin
                        mem_addr_ok <= 1'b1;
                    end else begin
                        mem_data_ok <= 1'b1;
                        mem_rdata   <= mem[widx];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 40;

    logic                  clk;
    logic                  rstn;
    logic                  valid;
    dcache_pkg::addr_t     addr;
    dcache_pkg::word_t     wdata;
    dcache_pkg::strb_t     wstrb;
    logic                  is_write;
    logic                  uncached;
    logic                  is_op;
    dcache_pkg::cache_op_t op;
    logic                  flush;
    logic                  ready;
    dcache_pkg::word_t     rdata;
    logic                  rdata_valid;
    logic                  op_done;
    logic                  mem_req;
    logic                  mem_wr;
    dcache_pkg::addr_t     mem_addr;
    dcache_pkg::word_t     mem_wdata;
    dcache_pkg::strb_t     mem_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    dcache_pkg::word_t     mem_rdata;

    dcache_pkg::word_t image [1024];  // expected memory contents
    int error_count;
    int hit_count;
    int miss_count;

    dcache_top u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .is_write    (is_write),
        .uncached    (uncached),
        .is_op       (is_op),
        .op          (op),
        .flush       (flush),
        .ready       (ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .op_done     (op_done),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    mem_model u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic dcache_pkg::addr_t mk_addr(input int tag, input int idx);
        return dcache_pkg::addr_t'((tag << (dcache_pkg::index_width + dcache_pkg::offset_width))
                                   | (idx << dcache_pkg::offset_width));
    endfunction

    function automatic logic [9:0] word_index(input dcache_pkg::addr_t a);
        return a[11:2];
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        $display("ERROR %0t %s got %h expected %h", $time, name, got, expv);
        error_count++;
    endtask

    task automatic wait_ready(input string what);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!ready && cyc < wait_limit) begin
            @(negedge clk);
            cyc++;
        end
        if (!ready) begin
            $display("timeout: ready never rose for %s", what);
            error_count++;
        end
    endtask

    // present a request and hold it until the transfer edge
    task automatic send_req(input dcache_pkg::addr_t a, input bit wr, input dcache_pkg::word_t d,
                            input dcache_pkg::strb_t s, input bit unc, input bit opf,
                            input dcache_pkg::cache_op_t o);
        @(posedge clk);
        valid    <= 1'b1;
        addr     <= a;
        wdata    <= d;
        wstrb    <= s;
        is_write <= wr;
        uncached <= unc;
        is_op    <= opf;
        op       <= o;
        wait_ready("request acceptance");
        @(posedge clk);
        valid <= 1'b0;
        is_op <= 1'b0;
    endtask

    task automatic read_word(input dcache_pkg::addr_t a, input bit unc, input bit chk_path,
                             input bit exp_miss);
        int                cyc;
        bit                done;
        bit                went_mem;
        dcache_pkg::word_t expv;
        expv     = image[word_index(a)];
        cyc      = 0;
        done     = 1'b0;
        went_mem = 1'b0;
        send_req(a, 1'b0, '0, '0, unc, 1'b0, dcache_pkg::op_index_init);
        while (!done && cyc < wait_limit) begin
            @(negedge clk);
            cyc++;
            if (mem_req) begin
                went_mem = 1'b1;
                if (mem_wr !== 1'b0) value_error("mem_wr", 32'(mem_wr), 32'd0);
            end
            if (rdata_valid) begin
                done = 1'b1;
                if (rdata !== expv) value_error("rdata", rdata, expv);
            end
        end
        if (!done) begin
            $display("timeout: read of %h returned no data", a);
            error_count++;
        end
        if (went_mem) miss_count++;
        else          hit_count++;
        if (chk_path && went_mem != exp_miss) begin
            $display("read of %h: expected a %s", a, exp_miss ? "miss" : "hit");
            error_count++;
        end
        if (chk_path && !exp_miss && done && cyc != 1) begin
            $display("read hit of %h took %0d cycles", a, cyc);  // should be one
            error_count++;
        end
    endtask

    task automatic write_word(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                              input dcache_pkg::strb_t s, input bit unc);
        int         cyc;
        bit         done;
        logic [9:0] wi;
        wi   = word_index(a);
        cyc  = 0;
        done = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) image[wi][8*b +: 8] = d[8*b +: 8];
        end
        send_req(a, 1'b1, d, s, unc, 1'b0, dcache_pkg::op_index_init);
        while (!done && cyc < wait_limit) begin
            @(negedge clk);
            cyc++;
            if (mem_req && mem_wr && mem_addr_ok) begin
                done = 1'b1;
                if (mem_addr !== a) value_error("mem_addr", mem_addr, a);
                if (mem_wdata !== d) value_error("mem_wdata", mem_wdata, d);
                if (mem_wstrb !== s) value_error("mem_wstrb", 32'(mem_wstrb), 32'(s));
                if (ready !== 1'b1) value_error("ready", 32'(ready), 32'd1);
            end
        end
        if (!done) begin
            $display("timeout: write to %h never reached memory", a);
            error_count++;
        end
    endtask

    task automatic issue_op(input dcache_pkg::addr_t a, input dcache_pkg::cache_op_t o);
        send_req(a, 1'b0, '0, '0, 1'b0, 1'b1, o);
        @(negedge clk);
        if (op_done !== 1'b1) value_error("op_done", 32'(op_done), 32'd1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic miss_then_hit();
        read_word(mk_addr(1, 0), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(1, 0), 1'b0, 1'b1, 1'b0);
    endtask

    task automatic write_through();
        read_word(mk_addr(2, 1), 1'b0, 1'b1, 1'b1);
        write_word(mk_addr(2, 1), $urandom, 4'b0101, 1'b0);  // partial merge into the hit way
        read_word(mk_addr(2, 1), 1'b0, 1'b1, 1'b0);
        write_word(mk_addr(3, 2), $urandom, 4'hf, 1'b0);    // not cached, no allocate
        read_word(mk_addr(3, 2), 1'b0, 1'b1, 1'b1);
    endtask

    task automatic lru_replace();
        read_word(mk_addr(4, 3), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(5, 3), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(4, 3), 1'b0, 1'b1, 1'b0);
        read_word(mk_addr(6, 3), 1'b0, 1'b1, 1'b1);  // evicts B
        read_word(mk_addr(4, 3), 1'b0, 1'b1, 1'b0);
        read_word(mk_addr(5, 3), 1'b0, 1'b1, 1'b1);
    endtask

    task automatic uncached_access();
        read_word(mk_addr(7, 4), 1'b1, 1'b1, 1'b1);
        read_word(mk_addr(7, 4), 1'b1, 1'b1, 1'b1);
        read_word(mk_addr(7, 4), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(7, 4), 1'b0, 1'b1, 1'b0);
        read_word(mk_addr(7, 4), 1'b1, 1'b1, 1'b1);  // drops the cached copy
        read_word(mk_addr(7, 4), 1'b0, 1'b1, 1'b1);
    endtask

    task automatic cache_ops();
        // even tag lands in way 0 of a fresh set
        read_word(mk_addr(2, 5), 1'b0, 1'b1, 1'b1);
        issue_op(mk_addr(2, 5), dcache_pkg::op_index_inval);
        read_word(mk_addr(2, 5), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(2, 6), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(3, 6), 1'b0, 1'b1, 1'b1);
        issue_op(mk_addr(3, 6), dcache_pkg::op_index_init);  // odd tag bit selects way 1
        read_word(mk_addr(2, 6), 1'b0, 1'b1, 1'b0);  // way 0 untouched
        read_word(mk_addr(3, 6), 1'b0, 1'b1, 1'b1);
        read_word(mk_addr(9, 7), 1'b0, 1'b1, 1'b1);
        issue_op(mk_addr(9, 7), dcache_pkg::op_hit_inval);
        read_word(mk_addr(9, 7), 1'b0, 1'b1, 1'b1);
    endtask

    task automatic flush_lookup();
        dcache_pkg::addr_t a;
        a = mk_addr(10, 8);
        @(posedge clk);
        flush    <= 1'b1;
        valid    <= 1'b1;
        addr     <= a;
        is_write <= 1'b0;
        uncached <= 1'b0;
        wait_ready("flushed read");
        @(posedge clk);
        valid <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (mem_req !== 1'b0) value_error("mem_req", 32'(mem_req), 32'd0);
            if (rdata_valid !== 1'b0) value_error("rdata_valid", 32'(rdata_valid), 32'd0);
            if (ready !== 1'b0) value_error("ready", 32'(ready), 32'd0);
        end
        @(posedge clk);
        flush <= 1'b0;
        wait_ready("end of flush");
        read_word(a, 1'b0, 1'b1, 1'b1);  // abandoned lookup left nothing behind
    endtask

    task automatic random_traffic(input int n);
        dcache_pkg::addr_t a;
        for (int i = 0; i < n; i++) begin
            a = mk_addr(int'($urandom_range(15, 8)), int'($urandom_range(11, 8)));
            if ($urandom_range(1, 0) == 1) begin
                write_word(a, $urandom, dcache_pkg::strb_t'($urandom_range(15, 1)), 1'b0);
            end else begin
                read_word(a, 1'b0, 1'b0, 1'b0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rstn        = 1'b0;
        valid       = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = '0;
        is_write    = 1'b0;
        uncached    = 1'b0;
        is_op       = 1'b0;
        op          = dcache_pkg::op_index_init;
        flush       = 1'b0;
        error_count = 0;
        hit_count   = 0;
        miss_count  = 0;
        void'($urandom(11));
        for (int i = 0; i < 1024; i++) begin
            image[10'(i)] = $urandom;
            u_mem.set_word(10'(i), image[10'(i)]);
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        miss_then_hit();
        write_through();
        lru_replace();
        uncached_access();
        cache_ops();
        flush_lookup();
        random_traffic(24);

        repeat (2) @(posedge clk);
        $display("reads: %0d hits, %0d misses; errors: %0d", hit_count, miss_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/dcache_pkg.sv
src/dcache_req_buf.sv
src/dcache_store.sv
src/dcache_read_mux.sv
src/dcache_main_fsm.sv
src/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
